// ==== src/tag_pkg.sv ====
package tag_pkg;

  //////////////////////////////////////////////////
  // Tag network geometry

  // Clients hanging off the tag master
  localparam int NUM_CLIENTS = 13;
  // ID field width, wide enough to address 16 clients
  localparam int CLIENT_ID_W = 4;
  // One byte of payload per client
  localparam int PAYLOAD_W = 8;
  // DRAM timing parameter clients
  localparam int NUM_DMC_PARAMS = 10;

  // Start bit, ID, mode bit, payload
  localparam int PKT_LEN = 1 + CLIENT_ID_W + 1 + PAYLOAD_W;

  // Bit counter covers the longer of the ID and payload fields
  localparam int BIT_CNT_W = $clog2((PAYLOAD_W > CLIENT_ID_W) ? PAYLOAD_W : CLIENT_ID_W);

  //////////////////////////////////////////////////
  // Client numbering

  localparam int CLIENT_CORE           = 0;
  localparam int CLIENT_ROUTER         = 1;
  localparam int CLIENT_DMC_CTRL       = 2;
  // Parameter bytes p0 to p9 sit on clients 3 to 12
  localparam int CLIENT_DMC_PARAM_BASE = 3;

  //////////////////////////////////////////////////
  // Payload layout

  // Destination ID in the low bits of core and router payloads
  localparam int DID_W = 7;
  // Reset level in the top payload bit of the control clients
  localparam int CTRL_RESET_BIT = PAYLOAD_W - 1;
  // DMC bypass in bit 0 of the DMC control payload
  localparam int DMC_BYPASS_BIT = 0;

  typedef logic [CLIENT_ID_W-1:0] client_id_t;
  typedef logic [PAYLOAD_W-1:0]   tag_payload_t;
  typedef logic [DID_W-1:0]       did_t;

  // DRAM timing field types
  typedef logic [15:0] dmc_trefi_t;
  typedef logic [3:0]  dmc_nibble_t;
  typedef logic [1:0]  dmc_bank_w_t;

  // Master FSM
  typedef enum logic [1:0]
  {
    IDLE,
    ID,
    MODE,
    PAYLOAD
  } tag_state_e;

endpackage

// ==== src/tag_master.sv ====
module tag_master
  (
    input  logic                      tag_clk_i
  , input  logic                      rst_i
  , input  logic                      data_i
  , output logic                      wr_v_o
  , output tag_pkg::client_id_t       wr_id_o
  , output logic                      wr_mode_o
  , output tag_pkg::tag_payload_t     wr_data_o
  );

  // Last bit positions within the ID and payload fields
  localparam logic [tag_pkg::BIT_CNT_W-1:0] ID_LAST  =
    tag_pkg::BIT_CNT_W'(tag_pkg::CLIENT_ID_W - 1);
  localparam logic [tag_pkg::BIT_CNT_W-1:0] PAY_LAST =
    tag_pkg::BIT_CNT_W'(tag_pkg::PAYLOAD_W - 1);

  tag_pkg::tag_state_e            state_r;
  tag_pkg::tag_state_e            state_n;
  logic [tag_pkg::BIT_CNT_W-1:0]  cnt_r;
  logic [tag_pkg::BIT_CNT_W-1:0]  cnt_n;
  logic                           pkt_done;
  logic                           wr_v_r;

  // Field shift registers, loaded LSB first
  tag_pkg::client_id_t            id_r;
  logic                           mode_r;
  tag_pkg::tag_payload_t          data_r;

  //////////////////////////////////////////////////
  // Next state

  always_comb
  begin
    state_n  = state_r;
    cnt_n    = cnt_r;
    pkt_done = 1'b0;
    case (state_r)
      tag_pkg::IDLE:
      begin
        // Any 1 on the gated line is a start bit
        if (data_i)
        begin
          state_n = tag_pkg::ID;
          cnt_n   = '0;
        end
      end
      tag_pkg::ID:
      begin
        cnt_n = cnt_r + 1'b1;
        if (cnt_r == ID_LAST)
        begin
          state_n = tag_pkg::MODE;
        end
      end
      tag_pkg::MODE:
      begin
        // Single mode bit, then restart the count for the payload
        cnt_n   = '0;
        state_n = tag_pkg::PAYLOAD;
      end
      tag_pkg::PAYLOAD:
      begin
        cnt_n = cnt_r + 1'b1;
        if (cnt_r == PAY_LAST)
        begin
          // Back to IDLE so a start bit can follow right away
          state_n  = tag_pkg::IDLE;
          pkt_done = 1'b1;
        end
      end
      default:
      begin
        state_n = tag_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Control registers

  always_ff @(posedge tag_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= tag_pkg::IDLE;
      cnt_r   <= '0;
      wr_v_r  <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
      // Strobe lands the cycle after the last payload bit
      wr_v_r  <= pkt_done;
    end
  end

  // Field capture, held stable through the strobe cycle
  always_ff @(posedge tag_clk_i)
  begin
    if (state_r == tag_pkg::ID)
    begin
      id_r <= {data_i, id_r[tag_pkg::CLIENT_ID_W-1:1]};
    end
    if (state_r == tag_pkg::MODE)
    begin
      mode_r <= data_i;
    end
    if (state_r == tag_pkg::PAYLOAD)
    begin
      data_r <= {data_i, data_r[tag_pkg::PAYLOAD_W-1:1]};
    end
  end

  assign wr_v_o    = wr_v_r;
  assign wr_id_o   = id_r;
  assign wr_mode_o = mode_r;
  assign wr_data_o = data_r;

  //////////////////////////////////////////////////
  // Checks

  // One strobe per packet
  a_strobe_single : assert property (@(posedge tag_clk_i) disable iff (rst_i)
    wr_v_r |=> !wr_v_r);

  // After the strobe the FSM is idle or already on the next packet
  a_strobe_state : assert property (@(posedge tag_clk_i) disable iff (rst_i)
    wr_v_r |=> (state_r == tag_pkg::IDLE || state_r == tag_pkg::ID));

  // Fixed packet length from start bit to strobe
  a_pkt_len : assert property (@(posedge tag_clk_i) disable iff (rst_i)
    (state_r == tag_pkg::IDLE && data_i) |-> ##(tag_pkg::PKT_LEN) wr_v_r);

endmodule

// ==== src/tag_client_bank.sv ====
module tag_client_bank
  (
    input  logic                                              tag_clk_i
  , input  logic                                              rst_i
  , input  logic                                              wr_v_i
  , input  tag_pkg::client_id_t                               wr_id_i
  , input  logic                                              wr_mode_i
  , input  tag_pkg::tag_payload_t                             wr_data_i
  , output tag_pkg::tag_payload_t [tag_pkg::NUM_CLIENTS-1:0]  client_data_o
  , output logic [tag_pkg::NUM_CLIENTS-1:0]                   client_new_o
  );

  // Write accepted only for IDs that map to a real client
  logic                                             wr_ok;
  // One-hot client select for the current write
  logic [tag_pkg::NUM_CLIENTS-1:0]                  wr_sel;
  // Value stored by the write, zero for a reset write
  tag_pkg::tag_payload_t                            wr_val;

  tag_pkg::tag_payload_t [tag_pkg::NUM_CLIENTS-1:0] data_r;
  logic [tag_pkg::NUM_CLIENTS-1:0]                  new_r;

  //////////////////////////////////////////////////
  // Write decode

  // IDs 13 to 15 fall off the end of the chain
  assign wr_ok  = wr_v_i && (int'(wr_id_i) < tag_pkg::NUM_CLIENTS);
  assign wr_val = wr_mode_i ? wr_data_i : '0;

  always_comb
  begin
    wr_sel = '0;
    for (int i = 0; i < tag_pkg::NUM_CLIENTS; i++)
    begin
      if (wr_ok && (int'(wr_id_i) == i))
      begin
        wr_sel[i] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Client registers

  for (genvar i = 0; i < tag_pkg::NUM_CLIENTS; i++)
  begin : g_client
    always_ff @(posedge tag_clk_i)
    begin
      if (rst_i)
      begin
        // Default payload is zero so every reset line starts low
        data_r[i] <= '0;
        new_r[i]  <= 1'b0;
      end
      else
      begin
        // New flag is a single-cycle pulse per accepted write
        new_r[i] <= wr_sel[i];
        if (wr_sel[i])
        begin
          data_r[i] <= wr_val;
        end
      end
    end
  end

  assign client_data_o = data_r;
  assign client_new_o  = new_r;

  //////////////////////////////////////////////////
  // Checks

  // Master issues at most one write per cycle
  a_new_onehot : assert property (@(posedge tag_clk_i) disable iff (rst_i)
    $onehot0(new_r));

endmodule

// ==== src/dmc_param_unpack.sv ====
module dmc_param_unpack
  (
    input  logic                                                 tag_clk_i
  , input  logic                                                 rst_i
  , input  tag_pkg::tag_payload_t [tag_pkg::NUM_DMC_PARAMS-1:0]  param_i
  , input  logic [tag_pkg::NUM_DMC_PARAMS-1:0]                   param_new_i
  , input  logic                                                 dmc_reset_i
  , output tag_pkg::dmc_trefi_t                                  trefi_o
  , output tag_pkg::dmc_nibble_t                                 tmrd_o
  , output tag_pkg::dmc_nibble_t                                 trfc_o
  , output tag_pkg::dmc_nibble_t                                 trc_o
  , output tag_pkg::dmc_nibble_t                                 trp_o
  , output tag_pkg::dmc_nibble_t                                 tras_o
  , output tag_pkg::dmc_nibble_t                                 trrd_o
  , output tag_pkg::dmc_nibble_t                                 trcd_o
  , output tag_pkg::dmc_nibble_t                                 twr_o
  , output tag_pkg::dmc_nibble_t                                 twtr_o
  , output tag_pkg::dmc_nibble_t                                 trtp_o
  , output tag_pkg::dmc_nibble_t                                 tcas_o
  , output tag_pkg::dmc_nibble_t                                 col_width_o
  , output tag_pkg::dmc_nibble_t                                 row_width_o
  , output tag_pkg::dmc_nibble_t                                 init_cmd_cnt_o
  , output tag_pkg::dmc_bank_w_t                                 bank_width_o
  , output tag_pkg::dmc_bank_w_t                                 dqs_sel_cal_o
  , output logic                                                 params_valid_o
  );

  logic [tag_pkg::NUM_DMC_PARAMS-1:0] loaded_r;
  logic [tag_pkg::NUM_DMC_PARAMS-1:0] loaded_n;
  logic                               valid_r;

  //////////////////////////////////////////////////
  // Field mapping

  // Refresh interval spans p1:p0
  assign trefi_o        = {param_i[1], param_i[0]};
  assign tmrd_o         = param_i[2][3:0];
  assign trfc_o         = param_i[2][7:4];
  assign trc_o          = param_i[3][3:0];
  assign trp_o          = param_i[3][7:4];
  assign tras_o         = param_i[4][3:0];
  assign trrd_o         = param_i[4][7:4];
  assign trcd_o         = param_i[5][3:0];
  assign twr_o          = param_i[5][7:4];
  assign twtr_o         = param_i[6][3:0];
  assign trtp_o         = param_i[6][7:4];
  // CAS latency and column width each get their own nibble
  assign tcas_o         = param_i[7][3:0];
  assign col_width_o    = param_i[7][7:4];
  assign row_width_o    = param_i[8][3:0];
  assign bank_width_o   = param_i[8][5:4];
  // DQS select kept apart from bank width
  assign dqs_sel_cal_o  = param_i[9][1:0];
  assign init_cmd_cnt_o = param_i[9][7:4];

  //////////////////////////////////////////////////
  // Loaded tracking

  always_comb
  begin
    loaded_n = loaded_r;
    for (int i = 0; i < tag_pkg::NUM_DMC_PARAMS; i++)
    begin
      // Nonzero write marks the byte loaded, a zero write unmarks it
      if (param_new_i[i])
      begin
        loaded_n[i] = (param_i[i] != '0);
      end
    end
    // Controller in reset forgets everything loaded so far
    if (dmc_reset_i)
    begin
      loaded_n = '0;
    end
  end

  always_ff @(posedge tag_clk_i)
  begin
    if (rst_i)
    begin
      loaded_r <= '0;
      valid_r  <= 1'b0;
    end
    else
    begin
      loaded_r <= loaded_n;
      // Valid one cycle after the completing new pulse
      valid_r  <= &loaded_n;
    end
  end

  assign params_valid_o = valid_r;

  //////////////////////////////////////////////////
  // Checks

  // Valid only comes up right after a parameter update
  a_valid_rise : assert property (@(posedge tag_clk_i) disable iff (rst_i)
    $rose(valid_r) |-> $past(|param_new_i));

endmodule

// ==== src/config_top.sv ====
module config_top
  (
    input  logic                             tag_clk_i
  , input  logic                             rst_i
  , input  logic                             tag_en_i
  , input  logic                             tag_data_i
  , output logic                             core_reset_o
  , output tag_pkg::did_t                    core_did_o
  , output logic                             router_reset_o
  , output tag_pkg::did_t                    router_did_o
  , output logic                             dmc_reset_o
  , output logic                             dmc_bypass_o
  , output tag_pkg::dmc_trefi_t              trefi_o
  , output tag_pkg::dmc_nibble_t             tmrd_o
  , output tag_pkg::dmc_nibble_t             trfc_o
  , output tag_pkg::dmc_nibble_t             trc_o
  , output tag_pkg::dmc_nibble_t             trp_o
  , output tag_pkg::dmc_nibble_t             tras_o
  , output tag_pkg::dmc_nibble_t             trrd_o
  , output tag_pkg::dmc_nibble_t             trcd_o
  , output tag_pkg::dmc_nibble_t             twr_o
  , output tag_pkg::dmc_nibble_t             twtr_o
  , output tag_pkg::dmc_nibble_t             trtp_o
  , output tag_pkg::dmc_nibble_t             tcas_o
  , output tag_pkg::dmc_nibble_t             col_width_o
  , output tag_pkg::dmc_nibble_t             row_width_o
  , output tag_pkg::dmc_nibble_t             init_cmd_cnt_o
  , output tag_pkg::dmc_bank_w_t             bank_width_o
  , output tag_pkg::dmc_bank_w_t             dqs_sel_cal_o
  , output logic                             params_valid_o
  , output logic [tag_pkg::NUM_CLIENTS-1:0]  client_new_o
  );

  logic                                             tag_bit;
  logic                                             wr_v;
  tag_pkg::client_id_t                              wr_id;
  logic                                             wr_mode;
  tag_pkg::tag_payload_t                            wr_data;
  tag_pkg::tag_payload_t [tag_pkg::NUM_CLIENTS-1:0] client_data;
  tag_pkg::tag_payload_t                            core_payload;
  tag_pkg::tag_payload_t                            router_payload;
  tag_pkg::tag_payload_t                            dmc_ctrl_payload;
  logic                                             dmc_reset;

  //////////////////////////////////////////////////
  // Tag master and client bank

  // Disabled line reads as idle zeros
  assign tag_bit = tag_en_i & tag_data_i;

  tag_master u_master
    (.tag_clk_i ( tag_clk_i )
    ,.rst_i     ( rst_i     )
    ,.data_i    ( tag_bit   )
    ,.wr_v_o    ( wr_v      )
    ,.wr_id_o   ( wr_id     )
    ,.wr_mode_o ( wr_mode   )
    ,.wr_data_o ( wr_data   )
    );

  tag_client_bank u_bank
    (.tag_clk_i     ( tag_clk_i    )
    ,.rst_i         ( rst_i        )
    ,.wr_v_i        ( wr_v         )
    ,.wr_id_i       ( wr_id        )
    ,.wr_mode_i     ( wr_mode      )
    ,.wr_data_i     ( wr_data      )
    ,.client_data_o ( client_data  )
    ,.client_new_o  ( client_new_o )
    );

  //////////////////////////////////////////////////
  // Control payload slices

  assign core_payload     = client_data[tag_pkg::CLIENT_CORE];
  assign router_payload   = client_data[tag_pkg::CLIENT_ROUTER];
  assign dmc_ctrl_payload = client_data[tag_pkg::CLIENT_DMC_CTRL];

  // Reset in the top bit, destination ID below it
  assign core_reset_o   = core_payload[tag_pkg::CTRL_RESET_BIT];
  assign core_did_o     = core_payload[tag_pkg::DID_W-1:0];
  assign router_reset_o = router_payload[tag_pkg::CTRL_RESET_BIT];
  assign router_did_o   = router_payload[tag_pkg::DID_W-1:0];

  assign dmc_reset    = dmc_ctrl_payload[tag_pkg::CTRL_RESET_BIT];
  assign dmc_reset_o  = dmc_reset;
  assign dmc_bypass_o = dmc_ctrl_payload[tag_pkg::DMC_BYPASS_BIT];

  //////////////////////////////////////////////////
  // DRAM parameter unpacker

  dmc_param_unpack u_dmc
    (.tag_clk_i      ( tag_clk_i )
    ,.rst_i          ( rst_i     )
    ,.param_i        ( client_data[tag_pkg::CLIENT_DMC_PARAM_BASE +: tag_pkg::NUM_DMC_PARAMS] )
    ,.param_new_i    ( client_new_o[tag_pkg::CLIENT_DMC_PARAM_BASE +: tag_pkg::NUM_DMC_PARAMS] )
    ,.dmc_reset_i    ( dmc_reset      )
    ,.trefi_o        ( trefi_o        )
    ,.tmrd_o         ( tmrd_o         )
    ,.trfc_o         ( trfc_o         )
    ,.trc_o          ( trc_o          )
    ,.trp_o          ( trp_o          )
    ,.tras_o         ( tras_o         )
    ,.trrd_o         ( trrd_o         )
    ,.trcd_o         ( trcd_o         )
    ,.twr_o          ( twr_o          )
    ,.twtr_o         ( twtr_o         )
    ,.trtp_o         ( trtp_o         )
    ,.tcas_o         ( tcas_o         )
    ,.col_width_o    ( col_width_o    )
    ,.row_width_o    ( row_width_o    )
    ,.init_cmd_cnt_o ( init_cmd_cnt_o )
    ,.bank_width_o   ( bank_width_o   )
    ,.dqs_sel_cal_o  ( dqs_sel_cal_o  )
    ,.params_valid_o ( params_valid_o )
    );

endmodule

// ==== tests/tb_checker.sv ====
module tb_checker
  (
    input  logic tag_clk_i
  , input  logic rst_i
  , input  logic tag_en_i
  , input  logic tag_data_i
  );

  typedef enum int {D_IDLE, D_ID, D_MODE, D_PAY} dec_state_e;

  // Client bytes and new pulses as the bank should hold them
  tag_pkg::tag_payload_t              model_data [tag_pkg::NUM_CLIENTS];
  logic [tag_pkg::NUM_CLIENTS-1:0]    model_new;
  logic [tag_pkg::NUM_DMC_PARAMS-1:0] model_loaded;
  logic                               model_valid;

  // Packet decoder
  dec_state_e            dec_state;
  int                    dec_cnt;
  tag_pkg::client_id_t   dec_id;
  logic                  dec_mode;
  tag_pkg::tag_payload_t dec_data;

  // Decoded write waiting for the master's strobe cycle
  logic                  pend_v;
  tag_pkg::client_id_t   pend_id;
  logic                  pend_mode;
  tag_pkg::tag_payload_t pend_data;

  logic armed = 1'b0;
  int   mismatch_cnt = 0;
  int   pkt_cnt = 0;

  // Parameter byte p0 to p9
  function automatic tag_pkg::tag_payload_t pb(input int i);
    return model_data[tag_pkg::CLIENT_DMC_PARAM_BASE + i];
  endfunction

  //////////////////////////////////////////////////
  // Reference model

  always @(posedge tag_clk_i)
  begin : model_update
    logic                               bit_in;
    logic [tag_pkg::NUM_DMC_PARAMS-1:0] loaded_next;
    bit_in = tag_en_i & tag_data_i;
    if (rst_i)
    begin
      for (int i = 0; i < tag_pkg::NUM_CLIENTS; i++)
      begin
        model_data[i] = '0;
      end
      model_new    = '0;
      model_loaded = '0;
      model_valid  = 1'b0;
      dec_state    = D_IDLE;
      pend_v       = 1'b0;
      armed        = 1'b1;
    end
    else
    begin
      // Loaded mask follows the bytes and pulses from before this edge
      loaded_next = model_loaded;
      for (int i = 0; i < tag_pkg::NUM_DMC_PARAMS; i++)
      begin
        if (model_new[tag_pkg::CLIENT_DMC_PARAM_BASE + i])
        begin
          loaded_next[i] = (pb(i) != '0);
        end
      end
      if (model_data[tag_pkg::CLIENT_DMC_CTRL][tag_pkg::PAYLOAD_W-1])
      begin
        loaded_next = '0;
      end
      model_loaded = loaded_next;
      model_valid  = &loaded_next;
      // Write lands one edge after the last payload bit
      model_new = '0;
      if (pend_v && int'(pend_id) < tag_pkg::NUM_CLIENTS)
      begin
        model_data[pend_id] = pend_mode ? pend_data : '0;
        model_new[pend_id]  = 1'b1;
      end
      pend_v = 1'b0;
      case (dec_state)
        D_IDLE:
        begin
          if (bit_in)
          begin
            dec_state = D_ID;
            dec_cnt   = 0;
          end
        end
        D_ID:
        begin
          dec_id[dec_cnt] = bit_in;
          dec_cnt++;
          if (dec_cnt == tag_pkg::CLIENT_ID_W)
          begin
            dec_state = D_MODE;
          end
        end
        D_MODE:
        begin
          dec_mode  = bit_in;
          dec_cnt   = 0;
          dec_state = D_PAY;
        end
        default:
        begin
          dec_data[dec_cnt] = bit_in;
          dec_cnt++;
          if (dec_cnt == tag_pkg::PAYLOAD_W)
          begin
            pend_v    = 1'b1;
            pend_id   = dec_id;
            pend_mode = dec_mode;
            pend_data = dec_data;
            pkt_cnt++;
            dec_state = D_IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output comparison

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH %s: dut=%0h expected=%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge tag_clk_i)
  begin : compare
    tag_pkg::tag_payload_t core_b;
    tag_pkg::tag_payload_t router_b;
    tag_pkg::tag_payload_t ctrl_b;
    tag_pkg::tag_payload_t p [tag_pkg::NUM_DMC_PARAMS];
    core_b   = model_data[tag_pkg::CLIENT_CORE];
    router_b = model_data[tag_pkg::CLIENT_ROUTER];
    ctrl_b   = model_data[tag_pkg::CLIENT_DMC_CTRL];
    // Model bytes p0 to p9
    for (int i = 0; i < tag_pkg::NUM_DMC_PARAMS; i++)
    begin
      p[i] = pb(i);
    end
    if (armed)
    begin
      check_val("core_reset_o", tb_top.u_dut.core_reset_o, core_b[7]);
      check_val("core_did_o", tb_top.u_dut.core_did_o, core_b[6:0]);
      check_val("router_reset_o", tb_top.u_dut.router_reset_o, router_b[7]);
      check_val("router_did_o", tb_top.u_dut.router_did_o, router_b[6:0]);
      check_val("dmc_reset_o", tb_top.u_dut.dmc_reset_o, ctrl_b[7]);
      check_val("dmc_bypass_o", tb_top.u_dut.dmc_bypass_o, ctrl_b[0]);
      check_val("client_new_o", tb_top.u_dut.client_new_o, model_new);
      check_val("trefi_o", tb_top.u_dut.trefi_o, {p[1], p[0]});
      check_val("tmrd_o", tb_top.u_dut.tmrd_o, p[2][3:0]);
      check_val("trfc_o", tb_top.u_dut.trfc_o, p[2][7:4]);
      check_val("trc_o", tb_top.u_dut.trc_o, p[3][3:0]);
      check_val("trp_o", tb_top.u_dut.trp_o, p[3][7:4]);
      check_val("tras_o", tb_top.u_dut.tras_o, p[4][3:0]);
      check_val("trrd_o", tb_top.u_dut.trrd_o, p[4][7:4]);
      check_val("trcd_o", tb_top.u_dut.trcd_o, p[5][3:0]);
      check_val("twr_o", tb_top.u_dut.twr_o, p[5][7:4]);
      check_val("twtr_o", tb_top.u_dut.twtr_o, p[6][3:0]);
      check_val("trtp_o", tb_top.u_dut.trtp_o, p[6][7:4]);
      check_val("tcas_o", tb_top.u_dut.tcas_o, p[7][3:0]);
      check_val("col_width_o", tb_top.u_dut.col_width_o, p[7][7:4]);
      check_val("row_width_o", tb_top.u_dut.row_width_o, p[8][3:0]);
      check_val("bank_width_o", tb_top.u_dut.bank_width_o, p[8][5:4]);
      check_val("dqs_sel_cal_o", tb_top.u_dut.dqs_sel_cal_o, p[9][1:0]);
      check_val("init_cmd_cnt_o", tb_top.u_dut.init_cmd_cnt_o, p[9][7:4]);
      check_val("params_valid_o", tb_top.u_dut.params_valid_o, model_valid);
    end
  end

endmodule

// ==== tests/tb_top.sv ====
module tb_top;

  // Packet count and the gap between packets
  localparam int NUM_PKTS = 300;
  localparam int MAX_GAP  = 3;
  // 14 packet bits plus at most 3 idle cycles per slot, with room for reset and drain
  localparam int TIMEOUT_CYCLES = NUM_PKTS * 18 + 64;

  logic tag_clk_i;
  logic rst_i;
  logic tag_en_i;
  logic tag_data_i;

  // DUT outputs, named as the ports so the instance connects by name
  logic                            core_reset_o;
  tag_pkg::did_t                   core_did_o;
  logic                            router_reset_o;
  tag_pkg::did_t                   router_did_o;
  logic                            dmc_reset_o;
  logic                            dmc_bypass_o;
  tag_pkg::dmc_trefi_t             trefi_o;
  tag_pkg::dmc_nibble_t            tmrd_o, trfc_o, trc_o, trp_o, tras_o, trrd_o;
  tag_pkg::dmc_nibble_t            trcd_o, twr_o, twtr_o, trtp_o, tcas_o;
  tag_pkg::dmc_nibble_t            col_width_o, row_width_o, init_cmd_cnt_o;
  tag_pkg::dmc_bank_w_t            bank_width_o;
  tag_pkg::dmc_bank_w_t            dqs_sel_cal_o;
  logic                            params_valid_o;
  logic [tag_pkg::NUM_CLIENTS-1:0] client_new_o;

  integer seed;
  int     cycles = 0;
  int     other_errors = 0;

  config_top u_dut (.*);

  tb_checker u_chk
    (.tag_clk_i  ( tag_clk_i  )
    ,.rst_i      ( rst_i      )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    );

  //////////////////////////////////////////////////
  // Clock and run limit

  initial tag_clk_i = 1'b0;
  always #5 tag_clk_i = ~tag_clk_i;

  always @(posedge tag_clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  // One line cycle, driven just after the rising edge
  task automatic drive_bit(input logic en, input logic b);
    @(posedge tag_clk_i);
    #1;
    tag_en_i   = en;
    tag_data_i = b;
  endtask

  // Start bit, ID, mode, payload, all LSB first
  task automatic send_packet(input tag_pkg::client_id_t id, input logic mode,
                             input tag_pkg::tag_payload_t data);
    drive_bit(1'b1, 1'b1);
    for (int i = 0; i < tag_pkg::CLIENT_ID_W; i++)
    begin
      drive_bit(1'b1, id[i]);
    end
    drive_bit(1'b1, mode);
    for (int i = 0; i < tag_pkg::PAYLOAD_W; i++)
    begin
      drive_bit(1'b1, data[i]);
    end
  endtask

  // Idle cycles, junk on the data pin only while the enable is low
  task automatic idle_gap();
    int   n;
    logic en;
    n = $unsigned($random(seed)) % (MAX_GAP + 1);
    for (int i = 0; i < n; i++)
    begin
      en = $random(seed) & 1;
      drive_bit(en, en ? 1'b0 : 1'($random(seed)));
    end
  endtask

  initial
  begin
    seed       = 24032;
    rst_i      = 1'b1;
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    repeat (4) @(posedge tag_clk_i);
    #1;
    rst_i = 1'b0;
    for (int p = 0; p < NUM_PKTS; p++)
    begin
      idle_gap();
      // Mode 0 in about one packet in eight
      send_packet(tag_pkg::client_id_t'($random(seed)), (($random(seed) & 7) != 0),
                  tag_pkg::tag_payload_t'($random(seed)));
    end
    // Let the last write reach the outputs and the valid flag
    repeat (4) drive_bit(1'b0, 1'b0);
    if (u_chk.pkt_cnt != NUM_PKTS)
    begin
      other_errors++;
      $display("Packet count wrong: checker decoded %0d packets, %0d were sent",
               u_chk.pkt_cnt, NUM_PKTS);
    end
    $display("Run finished: %0d mismatches, %0d other errors",
             u_chk.mismatch_cnt, other_errors);
    if (u_chk.mismatch_cnt == 0 && other_errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/tag_pkg.sv
src/tag_master.sv
src/tag_client_bank.sv
src/dmc_param_unpack.sv
src/config_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== Bender.yml ====
package:
  name: tag_config

sources:
  - src/tag_pkg.sv
  - src/tag_master.sv
  - src/tag_client_bank.sv
  - src/dmc_param_unpack.sv
  - src/config_top.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_top.sv
